/* hw/agc_timer.sv */
`timescale 1ns/1ns

module agc_timer (
    input  logic               sim_clk,
    input  logic               rst_n,
    input  logic               sby,
    input  logic               alga,
    input  logic               mstrtp,
    input  logic               strt1,
    input  logic               strt2,
    input  logic               goj1,
    input  logic               mstp,
    input  logic               wl15,
    input  logic               wl16,
    output logic               rt,
    output logic               wt,
    output logic               ct,
    output timer_pkg::ring_t   p,
    output logic               fs01,
    output logic               sb0,
    output logic               sb1,
    output logic               sb2,
    output logic               sb4,
    output logic               edset,
    output timer_pkg::tpulse_t tp,
    output logic               stop,
    output logic               gojam,
    output logic               ovf,
    output logic               unf
);

    // divider strobes shared by all stages
    phase_if ph ();

    // four-cycle phase divider
    clock_divider u_clock_divider (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .stop    (stop),
        .ph      (ph.src)
    );

    // johnson ring and strobe decodes
    ring_counter u_ring_counter (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .ph      (ph.dst),
        .p       (p),
        .fs01    (fs01),
        .sb0     (sb0),
        .sb1     (sb1),
        .sb2     (sb2),
        .sb4     (sb4),
        .edset   (edset)
    );

    // T01 to T12 chain
    time_pulse_gen u_time_pulse_gen (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .ph      (ph.dst),
        .gojam   (gojam),
        .tp      (tp)
    );

    // restart and stop sampled at T12
    restart_ctrl u_restart_ctrl (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .ph      (ph.dst),
        .t12     (tp[timer_pkg::TP_LAST]),
        .sby     (sby),
        .alga    (alga),
        .mstrtp  (mstrtp),
        .strt1   (strt1),
        .strt2   (strt2),
        .goj1    (goj1),
        .mstp    (mstp),
        .stop    (stop),
        .gojam   (gojam)
    );

    // word overflow check on the sign bits
    wl_overflow u_wl_overflow (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .ph      (ph.dst),
        .wl15    (wl15),
        .wl16    (wl16),
        .ovf     (ovf),
        .unf     (unf)
    );

    // memory strobes out to the pins
    assign rt = ph.rt;
    assign wt = ph.wt;
    assign ct = ph.ct;

endmodule

/* hw/clock_divider.sv */
`timescale 1ns/1ns

module clock_divider (
    input  logic   sim_clk,
    input  logic   rst_n,
    input  logic   stop,
    phase_if.src   ph
);

    // current phase inside the four-cycle step
    timer_pkg::phase_e phase;
    // high when the next step pulse is an even one
    logic              even_next;

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            phase     <= timer_pkg::PH_RT;
            even_next <= 1'b0;
            ph.rt     <= 1'b0;
            ph.wt     <= 1'b0;
            ph.ct     <= 1'b0;
            ph.ringa  <= 1'b0;
            ph.ringb  <= 1'b0;
        end else begin
            // phase sequencer wraps every PHASE_COUNT cycles
            unique case (phase)
                timer_pkg::PH_RT:   phase <= timer_pkg::PH_WT;
                timer_pkg::PH_WT:   phase <= timer_pkg::PH_CT;
                timer_pkg::PH_CT:   phase <= timer_pkg::PH_STEP;
                timer_pkg::PH_STEP: phase <= timer_pkg::PH_RT;
                default:            phase <= timer_pkg::PH_RT;
            endcase
            // strobes are the registered phase decode
            ph.rt    <= (phase == timer_pkg::PH_RT);
            ph.wt    <= (phase == timer_pkg::PH_WT);
            ph.ct    <= (phase == timer_pkg::PH_CT);
            // step pulse alternates between odd and even
            ph.ringa <= (phase == timer_pkg::PH_STEP) && !even_next;
            ph.ringb <= (phase == timer_pkg::PH_STEP) && even_next;
            if (phase == timer_pkg::PH_STEP) begin
                even_next <= !even_next;
            end
        end
    end

    // odd steps are held back while stopped
    // which parks the pulse chain on T12
    assign ph.oddset = ph.ringa & ~stop;
    // even steps always pass
    assign ph.evnset = ph.ringb;

endmodule

/* hw/phase_if.sv */
`timescale 1ns/1ns

// strobes from the phase divider to the later timer stages
// every signal here is a single-cycle pulse
interface phase_if;

    // memory cycle strobes
    logic rt;
    logic wt;
    logic ct;
    // raw odd and even step pulses for the ring counter
    logic ringa;
    logic ringb;
    // step pulses for the time pulse chain
    logic oddset;
    logic evnset;

    // divider side
    modport src (output rt, wt, ct, ringa, ringb, oddset, evnset);

    // consumer side
    modport dst (input rt, wt, ct, ringa, ringb, oddset, evnset);

endinterface

/* hw/restart_ctrl.sv */
`timescale 1ns/1ns

module restart_ctrl (
    input  logic sim_clk,
    input  logic rst_n,
    phase_if.dst ph,
    input  logic t12,
    input  logic sby,
    input  logic alga,
    input  logic mstrtp,
    input  logic strt1,
    input  logic strt2,
    input  logic goj1,
    input  logic mstp,
    output logic stop,
    output logic gojam
);

    // any source asking for a restart
    logic start_req;
    // restart stop flag
    logic stopa;
    // manual stop flag
    logic mstp_q;
    // sample point at the even step of T12
    logic sample;

    assign start_req = sby | alga | mstrtp | strt1 | strt2 | goj1;
    assign sample    = ph.evnset & t12;

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            stopa  <= 1'b0;
            mstp_q <= 1'b0;
        end else if (sample) begin
            // both flags only change at the end of a memory cycle
            stopa  <= start_req;
            mstp_q <= mstp;
        end
    end

    // either flag holds the sequence
    assign stop  = stopa | mstp_q;
    // strt2 jams at once without waiting for T12
    assign gojam = strt2 | stopa;

endmodule

/* hw/ring_counter.sv */
`timescale 1ns/1ns

module ring_counter (
    input  logic            sim_clk,
    input  logic            rst_n,
    phase_if.dst            ph,
    output timer_pkg::ring_t p,
    output logic            fs01,
    output logic            sb0,
    output logic            sb1,
    output logic            sb2,
    output logic            sb4,
    output logic            edset
);

    // any step moves the ring
    logic step;
    // P01 goes from low to high on this step
    logic p01_rise;

    assign step     = ph.ringa | ph.ringb;
    // new P01 is the inverse of P05
    assign p01_rise = step & ~p[0] & ~p[timer_pkg::RING_WIDTH-1];

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            p    <= '0;
            fs01 <= 1'b0;
        end else begin
            if (step) begin
                // shift toward P05 with inverted P05 back into P01
                // ten states starting from all zeros
                p <= {p[timer_pkg::RING_WIDTH-2:0], ~p[timer_pkg::RING_WIDTH-1]};
            end
            // half-rate flag flips once per full ring turn
            if (p01_rise) begin
                fs01 <= ~fs01;
            end
        end
    end

    // strobe decodes straight from the ring state
    assign sb0   = p[1] & ~p[4];
    assign sb1   = p[4] & p[2];
    assign sb2   = p[4] & ~p[1];
    assign sb4   = p[1] & ~p[3];
    // P03 alone among its neighbours
    assign edset = p[2] & ~p[1] & ~p[3];

endmodule

/* hw/time_pulse_gen.sv */
`timescale 1ns/1ns

module time_pulse_gen (
    input  logic               sim_clk,
    input  logic               rst_n,
    phase_if.dst               ph,
    input  logic               gojam,
    output timer_pkg::tpulse_t tp
);

    // current pulse is one of T02 T04 ... T12
    logic on_even;
    // current pulse is one of T01 T03 ... T11
    logic on_odd;
    // step of the matching parity
    logic advance;

    // even pulses sit on the odd bit indices
    assign on_even = tp[1] | tp[3] | tp[5] | tp[7] | tp[9] | tp[timer_pkg::TP_LAST];
    assign on_odd  = tp[0] | tp[2] | tp[4] | tp[6] | tp[8] | tp[10];

    // odd step leaves an even pulse
    // even step leaves an odd pulse
    // a step of the wrong parity is ignored
    assign advance = (ph.oddset & on_even) | (ph.evnset & on_odd);

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            // come out of reset parked on T12
            tp <= timer_pkg::tpulse_t'(1) << timer_pkg::TP_LAST;
        end else if (gojam) begin
            // restart jam wins over any step
            tp <= timer_pkg::tpulse_t'(1) << timer_pkg::TP_LAST;
        end else if (advance) begin
            // next pulse in order and T12 wraps to T01
            tp <= {tp[timer_pkg::TP_LAST-1:0], tp[timer_pkg::TP_LAST]};
        end
    end

endmodule

/* hw/timer_pkg.sv */
package timer_pkg;

    // sim_clk cycles that make up one timer step
    localparam int PHASE_COUNT = 4;

    // stages in the johnson ring counter
    localparam int RING_WIDTH = 5;

    // time pulses per memory cycle
    localparam int TP_COUNT = 12;

    // bit of T12 in the pulse vector
    localparam int TP_LAST = 11;

    // divider phase inside a step
    // read then write then clear then the step pulse itself
    typedef enum logic [$clog2(PHASE_COUNT)-1:0] {
        PH_RT,
        PH_WT,
        PH_CT,
        PH_STEP
    } phase_e;

    // ring state with bit 0 as P01
    typedef logic [RING_WIDTH-1:0] ring_t;

    // one-hot time pulses with bit 0 as T01
    typedef logic [TP_COUNT-1:0] tpulse_t;

endpackage

/* hw/wl_overflow.sv */
`timescale 1ns/1ns

module wl_overflow (
    input  logic sim_clk,
    input  logic rst_n,
    phase_if.dst ph,
    input  logic wl15,
    input  logic wl16,
    output logic ovf,
    output logic unf
);

    // divide ct by two
    logic ct_half;
    // overflow strobe on every second ct
    logic ovf_stb;

    assign ovf_stb = ph.ct & ct_half;

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            ct_half <= 1'b0;
            ovf     <= 1'b0;
            unf     <= 1'b0;
        end else begin
            if (ph.ct) begin
                ct_half <= ~ct_half;
            end
            // sign bits 16 and 15 disagree
            // positive overflow when only bit 15 is set
            ovf <= ovf_stb & wl15 & ~wl16;
            // negative overflow when only bit 16 is set
            unf <= ovf_stb & wl16 & ~wl15;
        end
    end

endmodule

/* list.f */
hw/timer_pkg.sv
hw/phase_if.sv
hw/clock_divider.sv
hw/ring_counter.sv
hw/time_pulse_gen.sv
hw/restart_ctrl.sv
hw/wl_overflow.sv
hw/agc_timer.sv
sim/tb_clock.sv
sim/tb_agc_timer.sv

/* run.sh */
#!/usr/bin/env bash
# build the timer testbench with verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_agc_timer -Mdir obj_dir \
    > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_agc_timer > sim.log 2>&1
cat sim.log

grep -q "^TEST OK$" sim.log && exit 0 || exit 1

/* sim/tb_agc_timer.sv */
`timescale 1ns/1ns

module tb_agc_timer;

    localparam int NUM_CYCLES    = 6000;
    localparam int RESET_CYCLES  = 3;
    localparam int CLK_PERIOD_NS = 4;
    // whole run plus some slack
    localparam int WATCHDOG_NS   = (RESET_CYCLES + NUM_CYCLES + 1) * CLK_PERIOD_NS + 200;

    logic sim_clk;
    logic rst_n;
    logic sby, alga, mstrtp, strt1, strt2, goj1, mstp, wl15, wl16;
    logic rt, wt, ct, fs01, sb0, sb1, sb2, sb4, edset, stop, gojam, ovf, unf;
    timer_pkg::ring_t   p;
    timer_pkg::tpulse_t tp;

    integer seed;
    // model state with cyc counting cycles since reset release
    int   cyc;
    int   ring_steps;
    // current time pulse number 1 to 12
    int   tp_n;
    logic stopa_m, mstp_m, ovf_m, unf_m;
    // restart input bursts
    int   burst_sel, burst_left, gap_left;
    int   stop_cycles, ovf_cycles, unf_cycles;

    tb_clock u_clock (.clk(sim_clk));

    agc_timer DUT (.*);

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%0h expected 0x%0h at %0t ns",
                     name, actual, expected, $time);
            $display("TEST FAILED");
            $fatal(1, "run stopped at first error");
        end
    endtask

    // ring pattern after idx steps from all zeros
    function automatic logic [31:0] johnson_state(input int idx);
        // ones fill in from P01 for five steps
        if (idx <= 5) begin
            return (32'd1 << idx) - 32'd1;
        end
        // then zeros fill in from P01
        return (32'h1f << (idx - 5)) & 32'h1f;
    endfunction

    // one clock edge of the reference model on the inputs of the cycle just ended
    task automatic advance_model();
        logic stop_now;
        logic gojam_now;
        logic odd_step;
        logic even_step;
        logic start_req;
        logic at_t12;
        stop_now  = stopa_m | mstp_m;
        gojam_now = strt2 | stopa_m;
        // steps every 4th cycle with odd ones first
        odd_step  = (cyc % 8 == 4);
        even_step = (cyc > 0) && (cyc % 8 == 0);
        start_req = sby | alga | mstrtp | strt1 | strt2 | goj1;
        at_t12    = (tp_n == 12);
        // ct sits at cycles 3, 7, 11 and only every second one counts
        ovf_m = (cyc % 8 == 7) && wl15 && !wl16;
        unf_m = (cyc % 8 == 7) && wl16 && !wl15;
        if (even_step && at_t12) begin
            stopa_m = start_req;
            mstp_m  = mstp;
        end
        if (gojam_now) begin
            tp_n = 12;
        end else if (odd_step && !stop_now && (tp_n % 2 == 0)) begin
            tp_n = (tp_n == 12) ? 1 : tp_n + 1;
        end else if (even_step && (tp_n % 2 == 1)) begin
            tp_n = tp_n + 1;
        end
        if (odd_step || even_step) begin
            ring_steps++;
        end
        cyc++;
    endtask

    task automatic drive_inputs();
        int r;
        r = $random(seed);
        wl15 = r[0];
        wl16 = r[1];
        if (burst_left > 0) begin
            burst_left--;
            if (burst_left == 0) begin
                // mostly short gaps so a new burst can meet a pending stop release
                r = $random(seed);
                gap_left = (r[1:0] == 2'b00) ? 64 + 32'(r[7:2]) : 32'(r[4:2]);
            end
        end else if (gap_left > 0) begin
            gap_left--;
        end else begin
            r = $random(seed);
            burst_sel  = 32'(r[15:0] % 7);
            // spans a full pulse cycle and at least one even step at T12
            burst_left = 56 + 32'(r[21:16]);
        end
        sby    = (burst_left > 0) && (burst_sel == 0);
        alga   = (burst_left > 0) && (burst_sel == 1);
        mstrtp = (burst_left > 0) && (burst_sel == 2);
        strt1  = (burst_left > 0) && (burst_sel == 3);
        strt2  = (burst_left > 0) && (burst_sel == 4);
        goj1   = (burst_left > 0) && (burst_sel == 5);
        mstp   = (burst_left > 0) && (burst_sel == 6);
    endtask

    task automatic compare_outputs();
        logic [31:0] exp_p;
        exp_p = johnson_state(ring_steps % 10);
        check_value("rt", 32'(rt), 32'(cyc % 4 == 1));
        check_value("wt", 32'(wt), 32'(cyc % 4 == 2));
        check_value("ct", 32'(ct), 32'(cyc % 4 == 3));
        check_value("p", 32'(p), exp_p);
        // P01 rises on steps 1, 11, 21 and so on
        check_value("fs01", 32'(fs01), 32'(((ring_steps + 9) / 10) % 2));
        check_value("sb0", 32'(sb0), 32'(exp_p[1] & ~exp_p[4]));
        check_value("sb1", 32'(sb1), 32'(exp_p[4] & exp_p[2]));
        check_value("sb2", 32'(sb2), 32'(exp_p[4] & ~exp_p[1]));
        check_value("sb4", 32'(sb4), 32'(exp_p[1] & ~exp_p[3]));
        check_value("edset", 32'(edset), 32'(exp_p[2] & ~exp_p[1] & ~exp_p[3]));
        check_value("tp", 32'(tp), 32'd1 << (tp_n - 1));
        check_value("stop", 32'(stop), 32'(stopa_m | mstp_m));
        check_value("gojam", 32'(gojam), 32'(strt2 | stopa_m));
        check_value("ovf", 32'(ovf), 32'(ovf_m));
        check_value("unf", 32'(unf), 32'(unf_m));
        if (stop) begin
            stop_cycles++;
        end
        if (ovf) begin
            ovf_cycles++;
        end
        if (unf) begin
            unf_cycles++;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the test loop finished", WATCHDOG_NS);
        $display("TEST FAILED");
        $fatal(1, "simulation timed out");
    end

    initial begin
        seed = 17;
        rst_n = 1'b0;
        {sby, alga, mstrtp, strt1, strt2, goj1, mstp, wl15, wl16} = '0;
        cyc = 0;
        ring_steps = 0;
        tp_n = 12;
        {stopa_m, mstp_m, ovf_m, unf_m} = '0;
        burst_sel = 0;
        burst_left = 0;
        gap_left = 0;
        stop_cycles = 0;
        ovf_cycles = 0;
        unf_cycles = 0;
        repeat (RESET_CYCLES) @(posedge sim_clk);
        #1;
        rst_n = 1'b1;
        // reset values during the release cycle
        #1;
        compare_outputs();
        repeat (NUM_CYCLES) begin
            @(posedge sim_clk);
            advance_model();
            #1;
            drive_inputs();
            #1;
            compare_outputs();
        end
        $display("checked %0d cycles, stop high %0d, ovf %0d, unf %0d",
                 NUM_CYCLES, stop_cycles, ovf_cycles, unf_cycles);
        // the stop and overflow checks only mean something once each output went high
        if (stop_cycles == 0 || ovf_cycles == 0 || unf_cycles == 0) begin
            $display("random stimulus never raised stop, ovf or unf during the run");
            $display("TEST FAILED");
            $fatal(1, "stimulus did not reach every behavior");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
    output logic clk
);

    // half of the 4 ns period
    localparam int HALF_PERIOD_NS = 2;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD_NS clk = ~clk;
    end

endmodule
